// File: src/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data and instruction words share one width
`define CPU_WORD_W 16
`define CPU_ADDR_W 8

`define CPU_IM_DEPTH 256
`define CPU_DM_DEPTH 256

// opcode sits in ir[15:10], operand address in ir[7:0]
`define CPU_OPC_LSB 10

`endif

// File: src/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    typedef enum logic [5:0] {
        op_nop    = 6'd0,
        op_ldac   = 6'd1,
        op_ldiac  = 6'd2,
        op_stac   = 6'd3,
        op_mvacar = 6'd4,
        op_mvacr  = 6'd5,
        op_mvacr1 = 6'd6,
        op_mvacr2 = 6'd7,
        op_mvacr3 = 6'd8,
        op_mvacr4 = 6'd9,
        op_mvr1ac = 6'd10,
        op_mvr2ac = 6'd11,
        op_mvr3ac = 6'd12,
        op_mvr4ac = 6'd13,
        op_add    = 6'd14,
        op_sub    = 6'd15,
        op_mult   = 6'd16,
        op_lshift = 6'd17,
        op_inac   = 6'd18,
        op_clac   = 6'd19,
        op_jpnz   = 6'd20,
        op_jmpz   = 6'd21,
        op_endop  = 6'd22
    } opcode_e;

    typedef enum logic [4:0] {
        st_idle,
        st_start,
        st_fetch1,
        st_fetch2,
        st_ldac1,
        st_ldac2,
        st_ldiac1,
        st_ldiac2,
        st_exec1, // all single cycle opcodes
        st_jump1,
        st_endop1
    } state_e;

    typedef enum logic [3:0] {
        src_none,
        src_im,
        src_dm,
        src_ac,
        src_r,
        src_r1,
        src_r2,
        src_r3,
        src_r4,
        src_ir_operand
    } bus_src_e;

    typedef enum logic [2:0] {
        alu_pass,
        alu_add,
        alu_sub,
        alu_mult,
        alu_lshift
    } alu_op_e;

    typedef struct packed {
        logic pc;
        logic ar;
        logic ir;
        logic ac;
        logic r;
        logic r1;
        logic r2;
        logic r3;
        logic r4;
        logic dm;
    } reg_mask_t;

    typedef struct packed {
        bus_src_e  bus_src;
        alu_op_e   alu_op;
        logic      alu_to_ac;
        reg_mask_t write_en;
        reg_mask_t inc_en;
        reg_mask_t clr_en;
    } ctrl_t;

    typedef struct packed {
        logic                   valid;
        logic                   we;
        logic                   sel_dm; // 0 selects instruction memory
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_WORD_W-1:0] wdata;
    } host_req_t;

endpackage

// File: src/control_unit.sv
`include "cpu_defines.svh"

module control_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [`CPU_WORD_W-1:0] ir,
    input  logic                   zero,
    output cpu_pkg::ctrl_t         ctrl,
    output logic                   busy,
    output logic                   done
);

    cpu_pkg::state_e  state;
    cpu_pkg::state_e  state_nxt;
    cpu_pkg::opcode_e opcode;

    assign opcode = cpu_pkg::opcode_e'(ir[`CPU_OPC_LSB +: $bits(cpu_pkg::opcode_e)]);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cpu_pkg::st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    assign busy = (state != cpu_pkg::st_idle);
    assign done = (state == cpu_pkg::st_endop1);

    always_comb begin
        state_nxt = state;
        case (state)
            cpu_pkg::st_idle: begin
                if (start) begin
                    state_nxt = cpu_pkg::st_start;
                end
            end
            cpu_pkg::st_start:  state_nxt = cpu_pkg::st_fetch1;
            cpu_pkg::st_fetch1: state_nxt = cpu_pkg::st_fetch2;
            cpu_pkg::st_fetch2: begin
                case (opcode) // ir was loaded in fetch1
                    cpu_pkg::op_ldac:  state_nxt = cpu_pkg::st_ldac1;
                    cpu_pkg::op_ldiac: state_nxt = cpu_pkg::st_ldiac1;
                    cpu_pkg::op_jpnz,
                    cpu_pkg::op_jmpz:  state_nxt = cpu_pkg::st_jump1;
                    cpu_pkg::op_endop: state_nxt = cpu_pkg::st_endop1;
                    default:           state_nxt = cpu_pkg::st_exec1;
                endcase
            end
            cpu_pkg::st_ldac1:  state_nxt = cpu_pkg::st_ldac2;
            cpu_pkg::st_ldac2:  state_nxt = cpu_pkg::st_fetch1;
            cpu_pkg::st_ldiac1: state_nxt = cpu_pkg::st_ldiac2;
            cpu_pkg::st_ldiac2: state_nxt = cpu_pkg::st_fetch1;
            cpu_pkg::st_exec1:  state_nxt = cpu_pkg::st_fetch1;
            cpu_pkg::st_jump1:  state_nxt = cpu_pkg::st_fetch1;
            cpu_pkg::st_endop1: state_nxt = cpu_pkg::st_idle;
            default:            state_nxt = cpu_pkg::st_idle;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (state)
            cpu_pkg::st_start: begin
                ctrl.clr_en.pc = 1'b1;
                ctrl.clr_en.ac = 1'b1;
                ctrl.clr_en.r  = 1'b1;
            end
            cpu_pkg::st_fetch1: begin
                ctrl.bus_src     = cpu_pkg::src_im; // im addressed by pc
                ctrl.write_en.ir = 1'b1;
            end
            cpu_pkg::st_fetch2: begin
                ctrl.inc_en.pc = 1'b1;
            end
            cpu_pkg::st_ldac1: begin
                ctrl.bus_src     = cpu_pkg::src_ac;
                ctrl.write_en.ar = 1'b1;
            end
            cpu_pkg::st_ldiac1: begin
                ctrl.bus_src     = cpu_pkg::src_ir_operand;
                ctrl.write_en.ar = 1'b1;
            end
            cpu_pkg::st_ldac2,
            cpu_pkg::st_ldiac2: begin
                ctrl.bus_src     = cpu_pkg::src_dm; // dm addressed by ar
                ctrl.write_en.ac = 1'b1;
            end
            cpu_pkg::st_jump1: begin
                if ((opcode == cpu_pkg::op_jpnz && !zero) ||
                    (opcode == cpu_pkg::op_jmpz && zero)) begin
                    ctrl.bus_src     = cpu_pkg::src_ir_operand;
                    ctrl.write_en.pc = 1'b1;
                end
            end
            cpu_pkg::st_exec1: begin
                case (opcode)
                    cpu_pkg::op_stac: begin
                        ctrl.bus_src     = cpu_pkg::src_ac;
                        ctrl.write_en.dm = 1'b1;
                    end
                    cpu_pkg::op_mvacar: begin
                        ctrl.bus_src     = cpu_pkg::src_ac;
                        ctrl.write_en.ar = 1'b1;
                    end
                    cpu_pkg::op_mvacr: begin
                        ctrl.bus_src    = cpu_pkg::src_ac;
                        ctrl.write_en.r = 1'b1;
                    end
                    cpu_pkg::op_mvacr1: begin
                        ctrl.bus_src     = cpu_pkg::src_ac;
                        ctrl.write_en.r1 = 1'b1;
                    end
                    cpu_pkg::op_mvacr2: begin
                        ctrl.bus_src     = cpu_pkg::src_ac;
                        ctrl.write_en.r2 = 1'b1;
                    end
                    cpu_pkg::op_mvacr3: begin
                        ctrl.bus_src     = cpu_pkg::src_ac;
                        ctrl.write_en.r3 = 1'b1;
                    end
                    cpu_pkg::op_mvacr4: begin
                        ctrl.bus_src     = cpu_pkg::src_ac;
                        ctrl.write_en.r4 = 1'b1;
                    end
                    cpu_pkg::op_mvr1ac: begin
                        ctrl.bus_src     = cpu_pkg::src_r1;
                        ctrl.write_en.ac = 1'b1;
                    end
                    cpu_pkg::op_mvr2ac: begin
                        ctrl.bus_src     = cpu_pkg::src_r2;
                        ctrl.write_en.ac = 1'b1;
                    end
                    cpu_pkg::op_mvr3ac: begin
                        ctrl.bus_src     = cpu_pkg::src_r3;
                        ctrl.write_en.ac = 1'b1;
                    end
                    cpu_pkg::op_mvr4ac: begin
                        ctrl.bus_src     = cpu_pkg::src_r4;
                        ctrl.write_en.ac = 1'b1;
                    end
                    cpu_pkg::op_add: begin
                        ctrl.alu_op    = cpu_pkg::alu_add;
                        ctrl.alu_to_ac = 1'b1;
                    end
                    cpu_pkg::op_sub: begin
                        ctrl.alu_op    = cpu_pkg::alu_sub;
                        ctrl.alu_to_ac = 1'b1;
                    end
                    cpu_pkg::op_mult: begin
                        ctrl.alu_op    = cpu_pkg::alu_mult;
                        ctrl.alu_to_ac = 1'b1;
                    end
                    cpu_pkg::op_lshift: begin
                        ctrl.alu_op    = cpu_pkg::alu_lshift;
                        ctrl.alu_to_ac = 1'b1;
                    end
                    cpu_pkg::op_inac: ctrl.inc_en.ac = 1'b1;
                    cpu_pkg::op_clac: ctrl.clr_en.ac = 1'b1;
                    default: ; // nop and unlisted codes
                endcase
            end
            default: ;
        endcase
    end

    // endop1 is left for idle on the very next edge
    a_done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held high for two cycles");

    a_bus_one_target: assert property (@(posedge clk) disable iff (rst)
        $onehot0(ctrl.write_en))
        else $error("more than one bus target written in one cycle");

endmodule

// File: src/datapath.sv
`include "cpu_defines.svh"

module datapath (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_pkg::ctrl_t         ctrl,
    input  logic [`CPU_WORD_W-1:0] im_rdata,
    input  logic [`CPU_WORD_W-1:0] dm_rdata,
    output logic [`CPU_ADDR_W-1:0] pc,
    output logic [`CPU_ADDR_W-1:0] ar,
    output logic [`CPU_WORD_W-1:0] ac,
    output logic [`CPU_WORD_W-1:0] ir,
    output logic                   zero
);

    localparam int PAD_W = `CPU_WORD_W - `CPU_ADDR_W;

    logic [`CPU_WORD_W-1:0] r;
    logic [`CPU_WORD_W-1:0] r1;
    logic [`CPU_WORD_W-1:0] r2;
    logic [`CPU_WORD_W-1:0] r3;
    logic [`CPU_WORD_W-1:0] r4;

    logic [`CPU_WORD_W-1:0] bus;
    logic [`CPU_WORD_W-1:0] alu_result;
    logic [`CPU_WORD_W-1:0] ac_d;
    logic                   ac_we;
    logic [`CPU_WORD_W-1:0] pc_nxt;
    logic [`CPU_WORD_W-1:0] ar_nxt;

    // clear wins over increment, increment over load
    function automatic logic [`CPU_WORD_W-1:0] reg_next(
        input logic [`CPU_WORD_W-1:0] cur,
        input logic [`CPU_WORD_W-1:0] d,
        input logic                   clr,
        input logic                   inc,
        input logic                   we
    );
        if (clr) begin
            return '0;
        end else if (inc) begin
            return cur + 1'b1;
        end else if (we) begin
            return d;
        end
        return cur;
    endfunction

    always_comb begin
        case (ctrl.bus_src)
            cpu_pkg::src_im:         bus = im_rdata;
            cpu_pkg::src_dm:         bus = dm_rdata;
            cpu_pkg::src_ac:         bus = ac;
            cpu_pkg::src_r:          bus = r;
            cpu_pkg::src_r1:         bus = r1;
            cpu_pkg::src_r2:         bus = r2;
            cpu_pkg::src_r3:         bus = r3;
            cpu_pkg::src_r4:         bus = r4;
            cpu_pkg::src_ir_operand: bus = {{PAD_W{1'b0}}, ir[`CPU_ADDR_W-1:0]};
            default:                 bus = '0;
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            cpu_pkg::alu_add:    alu_result = ac + r;
            cpu_pkg::alu_sub:    alu_result = ac - r;
            cpu_pkg::alu_mult:   alu_result = ac * r; // low 16 bits kept
            cpu_pkg::alu_lshift: alu_result = {ac[`CPU_WORD_W-2:0], 1'b0};
            default:             alu_result = bus;
        endcase
    end

    assign ac_d  = ctrl.alu_to_ac ? alu_result : bus;
    assign ac_we = ctrl.write_en.ac | ctrl.alu_to_ac;

    assign pc_nxt = reg_next({{PAD_W{1'b0}}, pc}, bus,
                             ctrl.clr_en.pc, ctrl.inc_en.pc, ctrl.write_en.pc);
    assign ar_nxt = reg_next({{PAD_W{1'b0}}, ar}, bus,
                             ctrl.clr_en.ar, ctrl.inc_en.ar, ctrl.write_en.ar);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            ar <= '0;
            ir <= '0;
            ac <= '0;
            r  <= '0;
            r1 <= '0;
            r2 <= '0;
            r3 <= '0;
            r4 <= '0;
        end else begin
            pc <= pc_nxt[`CPU_ADDR_W-1:0];
            ar <= ar_nxt[`CPU_ADDR_W-1:0];
            ir <= reg_next(ir, bus, ctrl.clr_en.ir, ctrl.inc_en.ir, ctrl.write_en.ir);
            ac <= reg_next(ac, ac_d, ctrl.clr_en.ac, ctrl.inc_en.ac, ac_we);
            r  <= reg_next(r, bus, ctrl.clr_en.r, ctrl.inc_en.r, ctrl.write_en.r);
            r1 <= reg_next(r1, bus, ctrl.clr_en.r1, ctrl.inc_en.r1, ctrl.write_en.r1);
            r2 <= reg_next(r2, bus, ctrl.clr_en.r2, ctrl.inc_en.r2, ctrl.write_en.r2);
            r3 <= reg_next(r3, bus, ctrl.clr_en.r3, ctrl.inc_en.r3, ctrl.write_en.r3);
            r4 <= reg_next(r4, bus, ctrl.clr_en.r4, ctrl.inc_en.r4, ctrl.write_en.r4);
        end
    end

    assign zero = (ac == '0);

endmodule

// File: src/memory_bank.sv
`include "cpu_defines.svh"

module memory_bank (
    input  logic                   clk,
    input  cpu_pkg::host_req_t     host_req,
    output logic [`CPU_WORD_W-1:0] host_rdata,
    input  logic [`CPU_ADDR_W-1:0] pc,
    input  logic [`CPU_ADDR_W-1:0] ar,
    input  logic [`CPU_WORD_W-1:0] ac,
    input  logic                   dm_we,
    output logic [`CPU_WORD_W-1:0] im_rdata,
    output logic [`CPU_WORD_W-1:0] dm_rdata
);

    logic [`CPU_WORD_W-1:0] im_mem [`CPU_IM_DEPTH];
    logic [`CPU_WORD_W-1:0] dm_mem [`CPU_DM_DEPTH];

    logic host_wr;
    logic host_rd;

    assign host_wr = host_req.valid && host_req.we;
    assign host_rd = host_req.valid && !host_req.we;

    // processor side reads are asynchronous
    assign im_rdata = im_mem[pc];
    assign dm_rdata = dm_mem[ar];

    always_ff @(posedge clk) begin
        if (host_wr && !host_req.sel_dm) begin
            im_mem[host_req.addr] <= host_req.wdata;
        end
    end

    // host valid is already masked while busy, so the two writers never meet
    always_ff @(posedge clk) begin
        if (host_wr && host_req.sel_dm) begin
            dm_mem[host_req.addr] <= host_req.wdata;
        end else if (dm_we) begin
            dm_mem[ar] <= ac; // stac
        end
    end

    always_ff @(posedge clk) begin
        if (host_rd) begin
            host_rdata <= dm_mem[host_req.addr]; // readback is data memory only
        end
    end

endmodule

// File: src/cpu_top.sv
`include "cpu_defines.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  cpu_pkg::host_req_t     host_req,
    output logic [`CPU_WORD_W-1:0] host_rdata,
    output logic                   busy,
    output logic                   done
);

    cpu_pkg::ctrl_t     ctrl;
    cpu_pkg::host_req_t host_req_idle;

    logic [`CPU_WORD_W-1:0] ir;
    logic [`CPU_WORD_W-1:0] ac;
    logic [`CPU_WORD_W-1:0] im_rdata;
    logic [`CPU_WORD_W-1:0] dm_rdata;
    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_ADDR_W-1:0] ar;
    logic                   zero;
    logic                   dm_we;

    always_comb begin
        host_req_idle       = host_req;
        host_req_idle.valid = host_req.valid && !busy; // host only while idle
    end

    assign dm_we = ctrl.write_en.dm;

    control_unit i_control_unit (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .ir    (ir),
        .zero  (zero),
        .ctrl  (ctrl),
        .busy  (busy),
        .done  (done)
    );

    datapath i_datapath (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .im_rdata (im_rdata),
        .dm_rdata (dm_rdata),
        .pc       (pc),
        .ar       (ar),
        .ac       (ac),
        .ir       (ir),
        .zero     (zero)
    );

    memory_bank i_memory_bank (
        .clk        (clk),
        .host_req   (host_req_idle),
        .host_rdata (host_rdata),
        .pc         (pc),
        .ar         (ar),
        .ac         (ac),
        .dm_we      (dm_we),
        .im_rdata   (im_rdata),
        .dm_rdata   (dm_rdata)
    );

endmodule

// File: dv/cpu_tb.sv
`include "cpu_defines.svh"

module cpu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DONE_TIMEOUT = 20000; // cycles per run
    localparam int MODEL_STEPS  = 20000;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   start;
    cpu_pkg::host_req_t     host_req;
    logic [`CPU_WORD_W-1:0] host_rdata;
    logic                   busy;
    logic                   done;

    // ISA model state, kept across runs like the DUT registers
    logic [`CPU_WORD_W-1:0] m_im [`CPU_IM_DEPTH];
    logic [`CPU_WORD_W-1:0] m_dm [`CPU_DM_DEPTH];
    bit                     m_touched [`CPU_DM_DEPTH];
    logic [`CPU_ADDR_W-1:0] m_pc;
    logic [`CPU_ADDR_W-1:0] m_ar;
    logic [`CPU_WORD_W-1:0] m_ac;
    logic [`CPU_WORD_W-1:0] m_r;
    logic [`CPU_WORD_W-1:0] m_rn [4]; // r1 to r4

    logic [`CPU_WORD_W-1:0] prog [$];
    int                     errors = 0;
    int                     checks = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;
    bit                     hung = 1'b0;

    cpu_top i_cpu_top (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .host_req   (host_req),
        .host_rdata (host_rdata),
        .busy       (busy),
        .done       (done)
    );

    always #50 clk = ~clk;

    task automatic check(string what, logic [`CPU_WORD_W-1:0] got, logic [`CPU_WORD_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic end_test(string name, int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("test %-10s %s", name, (errors == err_before) ? "ok" : "FAILED");
    endtask

    task automatic host_write(bit sel_dm, logic [7:0] addr, logic [15:0] data);
        @(posedge clk);
        host_req <= '{valid: 1'b1, we: 1'b1, sel_dm: sel_dm, addr: addr, wdata: data};
    endtask

    task automatic host_idle();
        @(posedge clk);
        host_req <= '0;
    endtask

    // read data comes back one cycle after the request
    task automatic host_read(logic [7:0] addr, output logic [15:0] data);
        @(posedge clk);
        host_req <= '{valid: 1'b1, we: 1'b0, sel_dm: 1'b1, addr: addr, wdata: 16'd0};
        @(posedge clk);
        host_req <= '0;
        @(negedge clk);
        data = host_rdata;
    endtask

    task automatic dm_write(logic [7:0] addr, logic [15:0] data);
        host_write(1'b1, addr, data);
        m_dm[addr] = data;
    endtask

    task automatic fill_dm();
        for (int a = 0; a < `CPU_DM_DEPTH; a++) begin
            dm_write(8'(a), 16'($urandom));
            m_touched[8'(a)] = 1'b0;
        end
        host_idle();
    endtask

    task automatic emit(cpu_pkg::opcode_e op, logic [7:0] opnd);
        prog.push_back({op, 2'b00, opnd});
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            host_write(1'b0, 8'(i), prog[i]);
            m_im[8'(i)] = prog[i];
        end
        host_idle();
    endtask

    task automatic model_run();
        cpu_pkg::opcode_e op;
        logic [7:0]       opnd;
        int               steps;
        m_pc = '0; // start state clears pc, ac and r only
        m_ac = '0;
        m_r = '0;
        for (steps = 0; steps < MODEL_STEPS; steps++) begin
            op = cpu_pkg::opcode_e'(m_im[m_pc][15:10]);
            opnd = m_im[m_pc][7:0];
            m_pc = m_pc + 8'd1;
            case (op)
                cpu_pkg::op_ldac, cpu_pkg::op_ldiac: begin
                    m_ar = (op == cpu_pkg::op_ldac) ? m_ac[7:0] : opnd;
                    m_ac = m_dm[m_ar];
                    m_touched[m_ar] = 1'b1;
                end
                cpu_pkg::op_stac: begin
                    m_dm[m_ar] = m_ac;
                    m_touched[m_ar] = 1'b1;
                end
                cpu_pkg::op_mvacar: m_ar = m_ac[7:0];
                cpu_pkg::op_mvacr:  m_r = m_ac;
                cpu_pkg::op_mvacr1, cpu_pkg::op_mvacr2, cpu_pkg::op_mvacr3, cpu_pkg::op_mvacr4:
                    m_rn[2'(int'(op) - int'(cpu_pkg::op_mvacr1))] = m_ac;
                cpu_pkg::op_mvr1ac, cpu_pkg::op_mvr2ac, cpu_pkg::op_mvr3ac, cpu_pkg::op_mvr4ac:
                    m_ac = m_rn[2'(int'(op) - int'(cpu_pkg::op_mvr1ac))];
                cpu_pkg::op_add:    m_ac = m_ac + m_r;
                cpu_pkg::op_sub:    m_ac = m_ac - m_r;
                cpu_pkg::op_mult:   m_ac = m_ac * m_r; // wraps to 16 bits
                cpu_pkg::op_lshift: m_ac = m_ac << 1;
                cpu_pkg::op_inac:   m_ac = m_ac + 16'd1;
                cpu_pkg::op_clac:   m_ac = '0;
                cpu_pkg::op_jpnz: begin
                    if (m_ac != '0) m_pc = opnd;
                end
                cpu_pkg::op_jmpz: begin
                    if (m_ac == '0) m_pc = opnd;
                end
                cpu_pkg::op_endop:  return;
                default: ;
            endcase
        end
        errors++;
        $display("model error: program did not reach endop within %0d steps", MODEL_STEPS);
    endtask

    task automatic run_program();
        int cycles;
        int pulses;
        int done_cycle;
        if (hung) return;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        pulses = 0;
        done_cycle = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (done) begin
                pulses++;
                done_cycle = cycles;
            end
        end while (busy && cycles < DONE_TIMEOUT);
        if (busy) begin
            hung = 1'b1;
            errors++;
            $display("timeout: processor still busy after %0d cycles", DONE_TIMEOUT);
            return;
        end
        check("done pulses in one run", 16'(pulses), 16'd1);
        check("cycles from done to idle", 16'(cycles - done_cycle), 16'd1);
        model_run();
    endtask

    task automatic compare_dm(string tag);
        logic [15:0] got;
        if (hung) return;
        for (int a = 0; a < `CPU_DM_DEPTH; a++) begin
            if (m_touched[8'(a)]) begin
                host_read(8'(a), got);
                check($sformatf("%s dm[%0d]", tag, a), got, m_dm[8'(a)]);
            end
        end
    endtask

    task automatic gen_straight(int len);
        cpu_pkg::opcode_e op;
        prog.delete();
        repeat (len) begin
            op = cpu_pkg::opcode_e'(6'($urandom_range(13, 0))); // nop through mvr4ac
            emit(op, 8'($urandom));
        end
        emit(cpu_pkg::op_endop, 8'd0);
    endtask

    task automatic gen_alu(int groups);
        prog.delete();
        repeat (groups) begin
            emit(cpu_pkg::op_ldiac, 8'($urandom));
            emit(cpu_pkg::op_mvacr, 8'd0);
            emit(cpu_pkg::op_ldiac, 8'($urandom)); // also picks the store address
            emit(cpu_pkg::opcode_e'(6'($urandom_range(19, 14))), 8'd0);
            emit(cpu_pkg::op_stac, 8'd0);
        end
        emit(cpu_pkg::op_endop, 8'd0);
    endtask

    initial begin
        int          e0;
        logic [15:0] got;
        logic [7:0]  addr;
        void'($urandom(22828));
        rst = 1'b1;
        start = 1'b0;
        host_req = '0;
        m_ar = '0;
        m_ac = '0;
        m_r = '0;
        foreach (m_rn[i]) m_rn[i] = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        e0 = errors;
        check("busy after reset", 16'(busy), 16'd0);
        check("done after reset", 16'(done), 16'd0);
        repeat (24) begin
            addr = 8'($urandom);
            dm_write(addr, 16'($urandom));
            host_idle();
            host_read(addr, got);
            check($sformatf("host readback dm[%0d]", addr), got, m_dm[addr]);
        end
        end_test("host_rw", e0);

        e0 = errors;
        repeat (3) begin
            fill_dm();
            gen_straight(40);
            load_program();
            run_program();
            compare_dm("straight");
        end
        end_test("moves", e0);

        e0 = errors;
        repeat (3) begin
            fill_dm();
            gen_alu(12);
            load_program();
            run_program();
            compare_dm("alu");
        end
        end_test("alu", e0);

        e0 = errors;
        fill_dm();
        dm_write(8'h10, 16'($urandom_range(20, 1))); // loop count
        dm_write(8'h11, 16'd1);
        dm_write(8'h12, 16'd0); // iteration tally
        host_idle();
        prog.delete();
        emit(cpu_pkg::op_ldiac, 8'h11);
        emit(cpu_pkg::op_mvacr, 8'd0);
        emit(cpu_pkg::op_ldiac, 8'h12); // loop head at 2
        emit(cpu_pkg::op_inac, 8'd0);
        emit(cpu_pkg::op_stac, 8'd0);
        emit(cpu_pkg::op_ldiac, 8'h10);
        emit(cpu_pkg::op_sub, 8'd0);
        emit(cpu_pkg::op_stac, 8'd0);
        emit(cpu_pkg::op_jpnz, 8'd2);
        emit(cpu_pkg::op_endop, 8'd0);
        load_program();
        run_program();
        compare_dm("countdown");
        repeat (4) begin
            fill_dm();
            dm_write(8'h20, $urandom_range(1, 0) ? 16'd0 : 16'($urandom_range(65535, 1)));
            host_idle();
            prog.delete();
            emit(cpu_pkg::op_ldiac, 8'h21);
            emit(cpu_pkg::op_mvacr1, 8'd0);
            emit(cpu_pkg::op_ldiac, 8'h20);
            emit(cpu_pkg::op_jmpz, 8'd7);
            emit(cpu_pkg::op_ldiac, 8'h22);
            emit(cpu_pkg::op_mvr1ac, 8'd0);
            emit(cpu_pkg::op_stac, 8'd0);
            emit(cpu_pkg::op_endop, 8'd0);
            load_program();
            run_program();
            m_touched[8'h22] = 1'b1; // skipped store must leave old word
            compare_dm("jmpz");
        end
        end_test("jumps", e0);

        e0 = errors;
        fill_dm();
        gen_straight(40);
        // stores r at the old ar, so a stale r from the first run shows up
        prog.insert(0, {cpu_pkg::op_stac, 2'b00, 8'd0});
        prog.insert(0, {cpu_pkg::op_add, 2'b00, 8'd0});
        load_program();
        run_program();
        repeat (4) @(negedge clk); // processor should stay idle
        check("busy after first run", 16'(busy), 16'd0);
        compare_dm("first run");
        run_program(); // same program, no reload
        repeat (4) @(negedge clk);
        check("busy after second run", 16'(busy), 16'd0);
        compare_dm("second run");
        end_test("rerun", e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+src
src/cpu_pkg.sv
src/control_unit.sv
src/datapath.sv
src/memory_bank.sv
src/cpu_top.sv
dv/cpu_tb.sv

// File: Makefile
TOP := cpu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
